// ==== project.f ====
+incdir+include
src/MidiPkg.sv
src/AudioPkg.sv
src/NoteEventDecoder.sv
src/MidiPitchIndex.sv
src/WaveShaper.sv
src/SampleCreditOut.sv
src/SynthVoiceTop.sv
testbench/SynthVoiceChecker.sv
testbench/SynthVoiceTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the synth voice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module SynthVoiceTb -Mdir obj_dir

simOut=$(./obj_dir/VSynthVoiceTb)
echo "$simOut"

if echo "$simOut" | grep -q "^TEST RESULT: PASS$"; then
	exit 0
fi
exit 1

// ==== testbench/SynthVoiceTb.sv ====
/*
 * Testbench for the single-voice MIDI synth
 * Consumer returns credits at random and never holds more than CREDIT_MAX
 * MIDI goes in only with all credits held, so the phase is frozen
 * Watchdog assumes no more than PLANNED_SAMPLES samples in the run
 */
`timescale 1ns/1ns

`include "synth_params.svh"

module SynthVoiceTb;

	import AudioPkg::*;

	localparam int CLK_PERIOD      = 8;
	localparam int PLANNED_SAMPLES = 1000;
	localparam int MARGIN_CYCLES   = 6000;

	// Controller, program change and sysex messages that the parser skips
	// Controller number 72 matches the held note
	localparam logic [7:0] OTHER_MSGS [11] = '{
		8'hB0, 8'h48, 8'h64, 8'h40, 8'h20, 8'hC0, 8'h05, 8'hF0, 8'h01, 8'h02, 8'hF7
	};

	// Lowest, middle and highest octave
	localparam int EDGE_NOTES [3] = '{0, 60, 127};

	logic       iCLK         = 1'b0;
	logic       iRST         = 1'b1;
	logic [7:0] midiByte     = 8'h00;
	logic       midiValid    = 1'b0;
	logic       creditReturn = 1'b0;
	audioOutT   audioOut;
	logic       audioValid;
	int         errorCount;
	int         sampleCount;

	// Consumer model
	logic returning = 1'b0;
	int   held      = 0;
	int   received  = 0;

	initial
	begin
		forever #(CLK_PERIOD / 2) iCLK = ~iCLK;
	end

	SynthVoiceTop uut (
		.iCLK         (iCLK),
		.iRST         (iRST),
		.midiByte     (midiByte),
		.midiValid    (midiValid),
		.creditReturn (creditReturn),
		.audioOut     (audioOut),
		.audioValid   (audioValid)
	);

	SynthVoiceChecker voiceChecker (
		.iCLK         (iCLK),
		.iRST         (iRST),
		.midiByte     (midiByte),
		.midiValid    (midiValid),
		.creditReturn (creditReturn),
		.audioOut     (audioOut),
		.audioValid   (audioValid),
		.errorCount   (errorCount),
		.sampleCount  (sampleCount)
	);

	// Takes samples and frees slots at random
	always @(negedge iCLK)
	begin
		int holdNow;
		holdNow = held + (audioValid ? 1 : 0);
		if (iRST)
		begin
			held         <= 0;
			creditReturn <= 1'b0;
		end
		else if (returning && holdNow > 0 && ($urandom % 4) != 0)
		begin
			held         <= holdNow - 1;
			creditReturn <= 1'b1;
		end
		else
		begin
			held         <= holdNow;
			creditReturn <= 1'b0;
		end
		received <= received + (audioValid ? 1 : 0);
	end

	// ------------------------------------------------------------------------
	// Stimulus tasks
	// ------------------------------------------------------------------------
	task automatic sendByte(input logic [7:0] value);
		@(negedge iCLK);
		midiByte  <= value;
		midiValid <= 1'b1;
		@(negedge iCLK);
		midiValid <= 1'b0;
	endtask

	task automatic noteMessage(input logic [7:0] status, input int note, input int velocity);
		sendByte(status);
		sendByte(8'(note));
		sendByte(8'(velocity));
	endtask

	// Waits until the consumer holds every credit and nothing is in flight
	task automatic freezePhase;
		returning <= 1'b0;
		@(negedge iCLK);
		while (held != `CREDIT_MAX)
			@(negedge iCLK);
	endtask

	task automatic playSamples(input int count);
		int target;
		target = received + count;
		returning <= 1'b1;
		while (received < target)
			@(negedge iCLK);
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial
	begin
		void'($urandom(32'h68f61fd7));
		repeat (4) @(negedge iCLK);
		iRST <= 1'b0;

		// Random notes on random channels
		repeat (16)
		begin
			freezePhase();
			noteMessage(8'h90 | 8'($urandom % 16), $urandom % 128, 1 + $urandom % 127);
			playSamples(1 + $urandom % 24);
		end

		foreach (EDGE_NOTES[i])
		begin
			freezePhase();
			noteMessage(8'h92, EDGE_NOTES[i], 100);
			playSamples(40);
		end

		// Note-off rules and running status
		freezePhase();
		noteMessage(8'h90, 64, 110);
		playSamples(8);
		freezePhase();
		noteMessage(8'h80, 65, 64);
		playSamples(8);
		freezePhase();
		sendByte(8'd64);
		sendByte(8'd0);
		playSamples(12);
		freezePhase();
		noteMessage(8'h90, 64, 90);
		sendByte(8'd70);
		sendByte(8'd0);
		playSamples(8);
		freezePhase();
		sendByte(8'd64);
		sendByte(8'd0);
		playSamples(8);

		// Non-note messages, then real-time bytes inside a note-on
		freezePhase();
		noteMessage(8'h91, 72, 80);
		foreach (OTHER_MSGS[i])
			sendByte(OTHER_MSGS[i]);
		playSamples(16);
		freezePhase();
		sendByte(8'h90);
		sendByte(8'hF8);
		sendByte(8'd76);
		sendByte(8'hFE);
		sendByte(8'd100);
		playSamples(16);

		// Long stretches without credits
		repeat (6)
		begin
			playSamples(1 + $urandom % 24);
			freezePhase();
			repeat (64 + $urandom % 256) @(negedge iCLK);
		end

		// Reset lands while a sample is in the pipeline
		returning <= 1'b1;
		@(negedge iCLK);
		while (!audioValid)
			@(negedge iCLK);
		// Next advance comes 13 cycles on and reaches shapedValid 2 cycles later
		repeat (15) @(negedge iCLK);
		iRST <= 1'b1;
		repeat (4) @(negedge iCLK);
		iRST <= 1'b0;
		// Phase starts again from zero
		freezePhase();
		noteMessage(8'h90, 69, 127);
		playSamples(24);
		freezePhase();

		$display("Checked %0d samples, %0d errors", sampleCount, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Two sample periods per planned sample, plus MIDI and idle stretches
	initial
	begin
		#((PLANNED_SAMPLES * `SAMPLE_DIV * 2 + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before the test sequence finished");
		$display("Checked %0d samples, %0d errors", sampleCount, errorCount);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== testbench/SynthVoiceChecker.sv ====
/*
 * Checker for the synth voice, compares every audioOut word with a model
 * Model expects the voice to stay fixed from advance to audioValid,
 * so MIDI must only be sent while the consumer holds all credits
 * Phase model is split into integer and fraction like the hardware
 */
`timescale 1ns/1ns

`include "synth_params.svh"

module SynthVoiceChecker (
	input  logic               iCLK,
	input  logic               iRST,
	input  logic [7:0]         midiByte,
	input  logic               midiValid,
	input  logic               creditReturn,
	input  AudioPkg::audioOutT audioOut,
	input  logic               audioValid,
	output int                 errorCount,
	output int                 sampleCount
);

	import MidiPkg::*;
	import AudioPkg::*;

	// Voice and parser model, rising edge
	logic modelGate   = 1'b0;
	int   modelNote   = 0;
	int   modelVel    = 0;
	int   runNibble   = 0;
	logic notePending = 1'b0;
	int   pendingNote = 0;
	int   returnedCount = 0;

	// Phase model and results, falling edge
	int phaseInt      = 0;
	int phaseFrac     = 0;
	int receivedCount = 0;
	int errors        = 0;
	int checked       = 0;

	assign errorCount  = errors;
	assign sampleCount = checked;

	// ------------------------------------------------------------------------
	// Reference rules
	// ------------------------------------------------------------------------
	// Octave ten stored, lower octaves halve per octave
	function automatic int stepFor(input int note);
		int base;
		base = int'(TOP_OCTAVE_STEP[note % 12]);
		return base >> (10 - note / 12);
	endfunction

	// Up over the first half cycle, down over the second
	function automatic int triangleOf(input int index);
		if (index >= 128)
			return 255 - 2 * (index - 128);
		return 2 * index;
	endfunction

	task automatic applyNote(input int note, input int velocity, input logic onStatus);
		if (onStatus && velocity != 0)
		begin
			modelGate = 1'b1;
			modelNote = note;
			modelVel  = velocity;
		end
		else if (note == modelNote)
			modelGate = 1'b0;
	endtask

	task automatic handleByte(input logic [7:0] value);
		// Real-time bytes F8 and up change nothing
		if (value < 8'hF8)
		begin
			if (value[7])
			begin
				notePending = 1'b0;
				runNibble   = (value[7:4] == 4'h8 || value[7:4] == 4'h9) ? value[7:4] : 0;
			end
			else if (runNibble != 0)
			begin
				if (!notePending)
				begin
					pendingNote = value;
					notePending = 1'b1;
				end
				else
				begin
					notePending = 1'b0;
					applyNote(pendingNote, value, runNibble == 9);
				end
			end
		end
	endtask

	task automatic checkSample;
		int step;
		int fracSum;
		int triValue;
		int expSample;
		logic [`SAMPLE_W-1:0] expBits;
		step      = stepFor(modelNote);
		fracSum   = phaseFrac + (step % (1 << `FRAC_W));
		phaseInt  = (phaseInt + (step >> `FRAC_W) + (fracSum >> `FRAC_W)) % (1 << `AUDIO_W);
		phaseFrac = fracSum % (1 << `FRAC_W);
		triValue  = triangleOf(phaseInt);
		expSample = modelGate ? (triValue - 128) * modelVel : 0;
		expBits   = expSample[`SAMPLE_W-1:0];
		if (audioOut.sample !== expBits)
		begin
			$display("FAILED audioOut.sample: expected %h, got %h", expBits, audioOut.sample);
			errors++;
		end
		if (audioOut.gate !== modelGate)
		begin
			$display("FAILED audioOut.gate: expected %h, got %h", modelGate, audioOut.gate);
			errors++;
		end
		checked++;
		receivedCount++;
		if (receivedCount - returnedCount > `CREDIT_MAX)
		begin
			$display("More samples arrived than credits were granted");
			errors++;
		end
	endtask

	// ------------------------------------------------------------------------
	// Monitors
	// ------------------------------------------------------------------------
	always @(posedge iCLK)
	begin
		if (iRST)
		begin
			modelGate     = 1'b0;
			modelNote     = 0;
			modelVel      = 0;
			runNibble     = 0;
			notePending   = 1'b0;
			returnedCount = 0;
		end
		else
		begin
			if (creditReturn)
				returnedCount++;
			if (midiValid)
				handleByte(midiByte);
		end
	end

	// Outputs settle after the rising edge
	always @(negedge iCLK)
	begin
		if (iRST)
		begin
			if (audioValid)
			begin
				$display("audioValid was high while reset was asserted");
				errors++;
			end
			phaseInt      = 0;
			phaseFrac     = 0;
			receivedCount = 0;
		end
		else if (audioValid)
			checkSample();
	end

endmodule

// ==== src/SynthVoiceTop.sv ====
/*
 * Single-voice MIDI tone generator
 * MIDI bytes in, velocity-scaled triangle samples out under credits
 * Three cycles from advance to audioValid, at most CREDIT_MAX unreturned
 */
`timescale 1ns/1ns

module SynthVoiceTop (
	input  logic               iCLK,
	input  logic               iRST,
	input  logic [7:0]         midiByte,
	input  logic               midiValid,
	input  logic               creditReturn,
	output AudioPkg::audioOutT audioOut,
	output logic               audioValid
);

	import MidiPkg::*;
	import AudioPkg::*;

	voiceStateT voice;
	logic       advance;
	phaseIntT   phaseIndex;
	logic       phaseValid;
	audioOutT   shaped;
	logic       shapedValid;

	// MIDI parsing, held note and gate
	NoteEventDecoder decoder (
		.iCLK      (iCLK),
		.iRST      (iRST),
		.midiByte  (midiByte),
		.midiValid (midiValid),
		.voice     (voice)
	);

	// Phase accumulator, stepped once per issued sample
	MidiPitchIndex pitchIndex (
		.iCLK       (iCLK),
		.iRST       (iRST),
		.advance    (advance),
		.voice      (voice),
		.phaseIndex (phaseIndex),
		.phaseValid (phaseValid)
	);

	WaveShaper shaper (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.phaseValid  (phaseValid),
		.phaseIndex  (phaseIndex),
		.voice       (voice),
		.shaped      (shaped),
		.shapedValid (shapedValid)
	);

	// Timer and credits close the loop back to the accumulator
	SampleCreditOut creditOut (
		.iCLK         (iCLK),
		.iRST         (iRST),
		.shaped       (shaped),
		.shapedValid  (shapedValid),
		.creditReturn (creditReturn),
		.advance      (advance),
		.audioOut     (audioOut),
		.audioValid   (audioValid)
	);

endmodule

// ==== src/SampleCreditOut.sv ====
/*
 * Sample-rate timer, credit flow control and output register
 * A tick without credit is dropped, the phase then stays put
 * Credits are taken at issue, so every advance owns a consumer slot
 * Consumer must never return more credits than it was sent samples
 */
`timescale 1ns/1ns

`include "synth_params.svh"

module SampleCreditOut (
	input  logic               iCLK,
	input  logic               iRST,
	input  AudioPkg::audioOutT shaped,
	input  logic               shapedValid,
	input  logic               creditReturn,
	output logic               advance,
	output AudioPkg::audioOutT audioOut,
	output logic               audioValid
);

	localparam int DIV_W = $clog2(`SAMPLE_DIV);
	localparam int CRD_W = $clog2(`CREDIT_MAX + 1);

	logic [DIV_W-1:0] divCount;
	logic [CRD_W-1:0] credits;
	logic             tick;
	logic             issue;

	// ------------------------------------------------------------------------
	// Free-running tick divider
	// ------------------------------------------------------------------------
	assign tick = divCount == DIV_W'(`SAMPLE_DIV - 1);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			divCount <= '0;
		else if (tick)
			divCount <= '0;
		else
			divCount <= divCount + 1'b1;
	end

	// ------------------------------------------------------------------------
	// Credits and advance
	// ------------------------------------------------------------------------
	assign issue = tick && (credits != '0);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			credits <= CRD_W'(`CREDIT_MAX);
			advance <= 1'b0;
		end
		else
		begin
			// Issue and return together leave the count unchanged
			case ({issue, creditReturn})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			advance <= issue;
		end
	end

	// ------------------------------------------------------------------------
	// Output register
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (shapedValid)
			audioOut <= shaped;
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			audioValid <= 1'b0;
		else
			audioValid <= shapedValid;
	end

	assert property (@(posedge iCLK) disable iff (iRST) credits <= CRD_W'(`CREDIT_MAX));

	// Consumer cannot free a slot that was never filled
	assert property (@(posedge iCLK) disable iff (iRST)
		creditReturn |-> credits != CRD_W'(`CREDIT_MAX));

endmodule

// ==== src/WaveShaper.sv ====
/*
 * Triangle from the phase index, scaled by note velocity
 * Triangle is centred on zero before scaling, range -128..127 times 0..127
 * Voice is sampled one cycle after the phase advance
 */
`timescale 1ns/1ns

`include "synth_params.svh"

module WaveShaper (
	input  logic                iCLK,
	input  logic                iRST,
	input  logic                phaseValid,
	input  AudioPkg::phaseIntT  phaseIndex,
	input  MidiPkg::voiceStateT voice,
	output AudioPkg::audioOutT  shaped,
	output logic                shapedValid
);

	import AudioPkg::*;

	phaseIntT                   doubled;
	phaseIntT                   triangle;
	logic signed [`AUDIO_W:0]   centred;
	sampleT                     product;

	// ------------------------------------------------------------------------
	// Triangle shape
	// ------------------------------------------------------------------------
	// Rising half doubles the low bits, falling half mirrors it
	assign doubled  = {phaseIndex[`AUDIO_W-2:0], 1'b0};
	assign triangle = phaseIndex[`AUDIO_W-1] ? ({`AUDIO_W{1'b1}} - doubled) : doubled;

	// Shift to a zero-centred signed value
	assign centred = $signed({1'b0, triangle}) - $signed((`AUDIO_W+1)'(1 << (`AUDIO_W-1)));

	// Velocity is unsigned, widened with a zero sign bit
	assign product = `SAMPLE_W'(centred) * `SAMPLE_W'($signed({1'b0, voice.velocity}));

	// ------------------------------------------------------------------------
	// Sample register
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (phaseValid)
		begin
			// Released voice outputs silence
			shaped.sample <= voice.gate ? product : '0;
			shaped.gate   <= voice.gate;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			shapedValid <= 1'b0;
		else
			shapedValid <= phaseValid;
	end

endmodule

// ==== src/MidiPitchIndex.sv ====
/*
 * Phase accumulator driven by the current note
 * Step is the top-octave entry shifted right by the octave distance
 * Fraction carry lands in the integer sum of the same advance
 * Phase runs on with gate low, a retrigger continues from it
 */
`timescale 1ns/1ns

`include "synth_params.svh"

module MidiPitchIndex (
	input  logic                iCLK,
	input  logic                iRST,
	input  logic                advance,
	input  MidiPkg::voiceStateT voice,
	output AudioPkg::phaseIntT  phaseIndex,
	output logic                phaseValid
);

	import MidiPkg::*;
	import AudioPkg::*;

	logic [3:0]       octave;
	logic [3:0]       semitone;
	stepT             step;
	phaseIntT         stepInt;
	phaseFracT        stepFrac;
	phaseFracT        phaseFrac;
	logic [`FRAC_W:0] fracSum;

	// ------------------------------------------------------------------------
	// Step lookup
	// ------------------------------------------------------------------------
	// Note 127 gives octave 10, so the shift never goes negative
	assign octave   = 4'(voice.note / 7'd12);
	assign semitone = 4'(voice.note % 7'd12);
	assign step     = TOP_OCTAVE_STEP[semitone] >> (TOP_OCTAVE - octave);

	assign stepInt  = step[STEP_W-1:`FRAC_W];
	assign stepFrac = step[`FRAC_W-1:0];

	// Top bit is the carry into the integer phase
	assign fracSum = {1'b0, phaseFrac} + {1'b0, stepFrac};

	// ------------------------------------------------------------------------
	// Accumulator
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			phaseIndex <= '0;
			phaseFrac  <= '0;
		end
		else if (advance)
		begin
			phaseIndex <= phaseIndex + stepInt + phaseIntT'(fracSum[`FRAC_W]);
			phaseFrac  <= fracSum[`FRAC_W-1:0];
		end
	end

	// New index visible the cycle after advance
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			phaseValid <= 1'b0;
		else
			phaseValid <= advance;
	end

endmodule

// ==== src/NoteEventDecoder.sv ====
/*
 * MIDI byte parser for note-on and note-off on any channel
 * Running status kept, real-time bytes pass without effect
 * Other messages are skipped up to the next status byte
 * Single voice where the last note-on wins and only a matching note-off releases it
 */
`timescale 1ns/1ns

module NoteEventDecoder (
	input  logic                iCLK,
	input  logic                iRST,
	input  logic [7:0]          midiByte,
	input  logic                midiValid,
	output MidiPkg::voiceStateT voice
);

	import MidiPkg::*;

	// Running status, cleared by any non-note status
	logic       haveStatus;
	logic       statusIsOn;
	// 0 none, 1 note byte held, 2 message complete
	logic [1:0] byteCount;
	logic [6:0] firstData;

	logic       isRealTime;
	logic       isStatus;
	logic       isNoteStatus;
	logic       dataAccepted;
	logic       eventDone;
	noteEventT  noteEvent;

	// ------------------------------------------------------------------------
	// Byte classification
	// ------------------------------------------------------------------------
	// F8 to FF may arrive anywhere, even inside a message
	assign isRealTime   = midiValid && (midiByte[7:3] == 5'b11111);
	assign isStatus     = midiValid && midiByte[7] && !isRealTime;
	assign isNoteStatus = (midiByte[7:4] == NOTE_ON_NIBBLE) ||
		(midiByte[7:4] == NOTE_OFF_NIBBLE);
	assign dataAccepted = midiValid && !midiByte[7] && haveStatus;
	assign eventDone    = dataAccepted && (byteCount == 2'd1);

	// Velocity zero on a note-on means release
	assign noteEvent.isOn     = statusIsOn && (midiByte[6:0] != 7'd0);
	assign noteEvent.note     = firstData;
	assign noteEvent.velocity = midiByte[6:0];

	// ------------------------------------------------------------------------
	// Parser state
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			haveStatus <= 1'b0;
			statusIsOn <= 1'b0;
			byteCount  <= 2'd0;
		end
		else if (isStatus)
		begin
			// Non-note status drops running status, data then skipped
			haveStatus <= isNoteStatus;
			statusIsOn <= midiByte[7:4] == NOTE_ON_NIBBLE;
			byteCount  <= 2'd0;
		end
		else if (dataAccepted)
		begin
			// After a complete message the next byte starts a new one
			byteCount <= (byteCount == 2'd1) ? 2'd2 : 2'd1;
		end
	end

	// Note number of the message in progress
	always_ff @(posedge iCLK)
	begin
		if (dataAccepted && (byteCount != 2'd1))
			firstData <= midiByte[6:0];
	end

	// ------------------------------------------------------------------------
	// Voice update, one cycle after the completing byte
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			voice <= '0;
		else if (eventDone)
		begin
			if (noteEvent.isOn)
			begin
				voice.gate     <= 1'b1;
				voice.note     <= noteEvent.note;
				voice.velocity <= noteEvent.velocity;
			end
			else if (noteEvent.note == voice.note)
				voice.gate <= 1'b0;
		end
	end

	// Counter stays in its three legal states
	assert property (@(posedge iCLK) disable iff (iRST) byteCount <= 2'd2);

endmodule

// ==== src/AudioPkg.sv ====
/*
 * Phase and sample types for the audio path
 * Samples are two's complement, gate travels with each sample
 */
package AudioPkg;

	`include "synth_params.svh"

	// Integer phase, indexes the triangle
	typedef logic [`AUDIO_W-1:0] phaseIntT;

	// Fractional phase, its carry feeds the integer part
	typedef logic [`FRAC_W-1:0] phaseFracT;

	// Signed output sample
	typedef logic signed [`SAMPLE_W-1:0] sampleT;

	// Output word
	// sample is zero whenever gate is low
	typedef struct packed {
		sampleT sample;
		logic   gate;
	} audioOutT;

endpackage

// ==== src/MidiPkg.sv ====
/*
 * MIDI event types and the pitch step table
 * Steps assume a 48 kHz sample rate and a 256-entry phase cycle
 * Only the top octave is stored, lower notes shift it right per octave
 */
package MidiPkg;

	`include "synth_params.svh"

	// Full phase step, integer part above the fraction
	localparam int STEP_W = `AUDIO_W + `FRAC_W;
	typedef logic [STEP_W-1:0] stepT;

	// Status nibbles the parser accepts
	localparam logic [3:0] NOTE_OFF_NIBBLE = 4'h8;
	localparam logic [3:0] NOTE_ON_NIBBLE  = 4'h9;

	// Octave of the stored table, notes 120 and up
	localparam logic [3:0] TOP_OCTAVE = 4'd10;

	typedef struct packed {
		logic       isOn;
		logic [6:0] note;
		logic [6:0] velocity;
	} noteEventT;

	typedef struct packed {
		logic       gate;
		logic [6:0] note;
		logic [6:0] velocity;
	} voiceStateT;

	// C10 up to B10, f * 256 / 48000 in 8.16 fixed point
	localparam stepT TOP_OCTAVE_STEP [12] = '{
		24'h2CA698, 24'h2F4E4B, 24'h321E69, 24'h351958,
		24'h3841A5, 24'h3B9A02, 24'h3F254D, 24'h42E689,
		24'h46E0F0, 24'h4B17E5, 24'h4F8F01, 24'h544A19
	};

endpackage

// ==== include/synth_params.svh ====
/*
 * Shared sizes for the single-voice MIDI synth
 * Phase is AUDIO_W.FRAC_W fixed point, the triangle needs AUDIO_W >= 2
 * SAMPLE_W must hold the velocity-scaled triangle (about AUDIO_W + 8 bits)
 * CREDIT_MAX is the depth of the consumer buffer, all credits held after reset
 */
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// Integer phase index, also the triangle resolution
`define AUDIO_W 8

// Fractional phase bits
`define FRAC_W 16

// Signed output sample width
`define SAMPLE_W 16

// Consumer buffer depth in samples
`define CREDIT_MAX 4

// Clock cycles per sample tick
`define SAMPLE_DIV 16

`endif
